// ==== run_sim.sh ====
#!/bin/sh
# build and run the store subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f verilog.f \
  --top-module store_subsystem_tb -o store_subsystem_sim \
  || { echo "build failed"; exit 1; }

./obj_dir/store_subsystem_sim > sim.log 2>&1
cat sim.log

grep -q "TEST FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

// ==== source/core_pkg.sv ====
`default_nettype none
`include "sq_defs.svh"

package core_pkg;

  typedef logic [`ROB_IDX_W-1:0] rob_idx_t;

  // queue slot pointer and occupancy count
  typedef logic [$clog2(`SQ_SIZE)-1:0]   sq_ptr_t;
  typedef logic [$clog2(`SQ_SIZE+1)-1:0] sq_cnt_t;

  // one store queue slot
  typedef struct packed {
    logic                valid;
    logic                addr_valid;
    mem_pkg::addr_t      addr;
    mem_pkg::mem_size_e  size;
    rob_idx_t            rob_idx;
    logic                data_valid;
    mem_pkg::mem_block_u data;
    // rob head reached it with data present
    logic                committed;
    // already handed to the cache port
    logic                issued;
  } sq_entry_t;

  // load search result
  typedef struct packed {
    logic                hit;
    logic                pending;
    mem_pkg::mem_block_u data;
  } fwd_result_t;

endpackage

`default_nettype wire

// ==== source/dcache_store_port.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "sq_defs.svh"

module dcache_store_port (
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       dc_req_valid_i,
  input  wire mem_pkg::store_req_t  dc_req_i,
  input  wire mem_pkg::addr_t       load_addr_i,
  input  wire mem_pkg::mem_size_e   load_size_i,
  output logic                      dc_req_accept_o,
  output logic                      dc_store_valid_o,
  output core_pkg::rob_idx_t        dc_store_rob_idx_o,
  output mem_pkg::mem_block_u       load_block_o
);
  import core_pkg::*;
  import mem_pkg::*;

  localparam int LINE_W = $clog2(`DC_LINES);

  // direct mapped, always hits
  mem_block_u        data_array [`DC_LINES];
  logic              busy;
  logic              take;
  logic [7:0]        st_mask;
  logic [LINE_W-1:0] st_line;
  logic [LINE_W-1:0] ld_line;
  rob_idx_t          busy_idx;

  // ========================================
  // store side
  // ========================================
  assign dc_req_accept_o = !busy;
  assign take            = dc_req_valid_i && dc_req_accept_o;
  assign st_mask         = lane_mask(dc_req_i.addr, dc_req_i.size);
  assign st_line         = dc_req_i.addr[3 +: LINE_W];

  // busy the cycle after accept, done one cycle later
  always_ff @(posedge clock) begin
    if (reset) begin
      busy             <= 1'b0;
      dc_store_valid_o <= 1'b0;
    end else begin
      busy             <= take;
      dc_store_valid_o <= busy;
    end
  end

  // rob index travels with the done pulse
  always_ff @(posedge clock) begin
    if (take) begin
      busy_idx <= dc_req_i.rob_idx;
    end
    if (busy) begin
      dc_store_rob_idx_o <= busy_idx;
    end
  end

  // only the selected byte lanes change
  always_ff @(posedge clock) begin
    if (take && (dc_req_i.cmd == MEM_STORE)) begin
      for (int j = 0; j < 8; j++) begin
        if (st_mask[j]) begin
          data_array[st_line].byte_level[j] <= dc_req_i.data.byte_level[j];
        end
      end
    end
  end

  // ========================================
  // load side, combinational read
  // ========================================
  assign ld_line      = load_addr_i[3 +: LINE_W];
  assign load_block_o = mask_block(data_array[ld_line], lane_mask(load_addr_i, load_size_i));

endmodule

`default_nettype wire

// ==== source/mem_pkg.sv ====
`default_nettype none
`include "sq_defs.svh"

package mem_pkg;

  // byte address, only low bits reach the array
  typedef logic [31:0] addr_t;

  typedef enum logic [1:0] {
    MEM_BYTE   = 2'd0,
    MEM_HALF   = 2'd1,
    MEM_WORD   = 2'd2,
    MEM_DOUBLE = 2'd3
  } mem_size_e;

  typedef enum logic {
    MEM_LOAD  = 1'b0,
    MEM_STORE = 1'b1
  } mem_cmd_e;

  // one doubleword, seen at four granularities
  typedef union packed {
    logic [7:0][7:0]  byte_level;
    logic [3:0][15:0] half_level;
    logic [1:0][31:0] word_level;
    logic [63:0]      dbbl_level;
  } mem_block_u;

  // request from queue head to the cache port
  typedef struct packed {
    addr_t                  addr;
    mem_size_e              size;
    mem_cmd_e               cmd;
    mem_block_u             data;
    logic [`ROB_IDX_W-1:0]  rob_idx;
  } store_req_t;

  // byte lanes touched by an aligned access
  function automatic logic [7:0] lane_mask(addr_t addr, mem_size_e size);
    logic [7:0] base;
    case (size)
      MEM_BYTE: base = 8'h01;
      MEM_HALF: base = 8'h03;
      MEM_WORD: base = 8'h0f;
      default:  base = 8'hff;
    endcase
    return base << addr[2:0];
  endfunction

  // zero every lane outside the mask
  function automatic mem_block_u mask_block(mem_block_u blk, logic [7:0] mask);
    mem_block_u res;
    res.dbbl_level = '0;
    for (int j = 0; j < 8; j++) begin
      if (mask[j]) begin
        res.byte_level[j] = blk.byte_level[j];
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire

// ==== source/sq_checkpoint.sv ====
`timescale 1ns/10ps
`default_nettype none

module sq_checkpoint (
  input  wire                clock,
  input  wire                reset,
  input  wire                branch_i,
  input  wire                restore_i,
  input  wire core_pkg::sq_ptr_t tail_i,
  output logic               restore_valid_o,
  output core_pkg::sq_ptr_t  restore_tail_o
);

  // a checkpoint is live
  logic held;

  // restore without a checkpoint is dropped here
  assign restore_valid_o = restore_i && held;

  always_ff @(posedge clock) begin
    if (reset) begin
      held <= 1'b0;
    end else if (branch_i) begin
      held <= 1'b1;
    end else if (restore_valid_o) begin
      held <= 1'b0;
    end
  end

  // tail as seen when the branch dispatched
  always_ff @(posedge clock) begin
    if (branch_i) begin
      restore_tail_o <= tail_i;
    end
  end

endmodule

`default_nettype wire

// ==== source/sq_defs.svh ====
`ifndef SQ_DEFS_SVH
`define SQ_DEFS_SVH

// store queue entries
// any power of two works
`define SQ_SIZE 8

// reorder buffer entries
`define ROB_SIZE 32

// rob index width, shared by both packages
`define ROB_IDX_W ($clog2(`ROB_SIZE))

// doublewords held by the data array
`define DC_LINES 16

`endif

// ==== source/store_forward.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "sq_defs.svh"

module store_forward (
  input  wire                                 load_valid_i,
  input  wire mem_pkg::addr_t                 load_addr_i,
  input  wire mem_pkg::mem_size_e             load_size_i,
  input  wire core_pkg::sq_entry_t [`SQ_SIZE-1:0] entries_i,
  input  wire core_pkg::sq_ptr_t              head_i,
  input  wire core_pkg::sq_cnt_t              count_i,
  output core_pkg::fwd_result_t               fwd_o
);
  import core_pkg::*;
  import mem_pkg::*;

  logic [7:0]                load_mask;
  logic [`SQ_SIZE-1:0][7:0]  st_mask;
  logic [`SQ_SIZE-1:0]       match;
  logic                      found;
  logic                      covers;
  sq_ptr_t                   sel;
  sq_ptr_t                   slot;

  assign load_mask = lane_mask(load_addr_i, load_size_i);

  // ========================================
  // per-slot overlap, age not yet applied
  // ========================================
  always_comb begin
    for (int i = 0; i < `SQ_SIZE; i++) begin
      st_mask[i] = lane_mask(entries_i[i].addr, entries_i[i].size);
      // unknown address counts as a possible alias
      match[i] = entries_i[i].valid &&
                 (!entries_i[i].addr_valid ||
                  ((entries_i[i].addr[31:3] == load_addr_i[31:3]) &&
                   (|(st_mask[i] & load_mask))));
    end
  end

  // ========================================
  // youngest first, tail-1 back to head
  // ========================================
  always_comb begin
    found = 1'b0;
    sel   = head_i;
    slot  = head_i;
    for (int k = 1; k <= `SQ_SIZE; k++) begin
      slot = head_i + sq_ptr_t'(count_i) - sq_ptr_t'(k);
      // only live slots, stop at the first hit
      if (!found && (k <= int'(count_i)) && match[slot]) begin
        found = 1'b1;
        sel   = slot;
      end
    end
  end

  // store must hold every byte the load wants
  assign covers = entries_i[sel].addr_valid && entries_i[sel].data_valid &&
                  ((st_mask[sel] & load_mask) == load_mask);

  always_comb begin
    fwd_o.hit     = load_valid_i && found && covers;
    // partial overlap or data still missing
    fwd_o.pending = load_valid_i && found && !covers;
    fwd_o.data    = mask_block(entries_i[sel].data, load_mask);
  end

endmodule

`default_nettype wire

// ==== source/store_queue.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "sq_defs.svh"

module store_queue (
  input  wire                                 clock,
  input  wire                                 reset,
  // dispatch
  input  wire                                 enq_valid_i,
  input  wire mem_pkg::mem_size_e             enq_size_i,
  input  wire core_pkg::rob_idx_t             enq_rob_idx_i,
  // execute writeback
  input  wire                                 data_valid_i,
  input  wire mem_pkg::addr_t                 data_addr_i,
  input  wire mem_pkg::mem_block_u            data_i,
  input  wire core_pkg::rob_idx_t             data_rob_idx_i,
  input  wire core_pkg::rob_idx_t             rob_head_i,
  // checkpoint
  input  wire                                 restore_valid_i,
  input  wire core_pkg::sq_ptr_t              restore_tail_i,
  // cache port
  input  wire                                 dc_req_accept_i,
  input  wire                                 dc_store_valid_i,
  output logic                                full_o,
  output core_pkg::sq_cnt_t                   free_slots_o,
  output logic                                store_ready_valid_o,
  output core_pkg::rob_idx_t                  store_ready_idx_o,
  output logic                                dc_req_valid_o,
  output mem_pkg::store_req_t                 dc_req_o,
  output core_pkg::sq_ptr_t                   tail_o,
  output core_pkg::sq_entry_t [`SQ_SIZE-1:0]  entries_o,
  output core_pkg::sq_ptr_t                   head_o,
  output core_pkg::sq_cnt_t                   count_o
);
  import core_pkg::*;
  import mem_pkg::*;

  sq_entry_t [`SQ_SIZE-1:0] sq;
  sq_ptr_t                  head;
  sq_ptr_t                  tail;
  sq_cnt_t                  count;

  logic                     do_enq;
  logic                     do_issue;
  logic                     do_free;
  // slots from the saved tail up to the live tail
  sq_ptr_t                  squash_span;
  sq_cnt_t                  squash_n;
  logic [`SQ_SIZE-1:0]      squash_mask;
  logic [`SQ_SIZE-1:0]      commit_mask;

  // ========================================
  // occupancy
  // ========================================
  assign full_o       = (count == sq_cnt_t'(`SQ_SIZE));
  assign free_slots_o = sq_cnt_t'(`SQ_SIZE) - count;

  // restore wins over a same-cycle enqueue
  assign do_enq   = enq_valid_i && !full_o && !restore_valid_i;
  assign do_issue = dc_req_valid_o && dc_req_accept_i;
  // done pulse always belongs to the head
  assign do_free  = dc_store_valid_i;

  assign squash_span = tail - restore_tail_i;
  assign squash_n    = restore_valid_i ? sq_cnt_t'(squash_span) : '0;

  always_comb begin
    for (int i = 0; i < `SQ_SIZE; i++) begin
      // distance from saved tail, wraps in pointer width
      squash_mask[i] = restore_valid_i &&
                       ((sq_ptr_t'(i) - restore_tail_i) < squash_span);
      // rob head points here and data is in
      commit_mask[i] = sq[i].valid && sq[i].data_valid && !sq[i].committed &&
                       (sq[i].rob_idx == rob_head_i);
    end
  end

  // ========================================
  // head request to the cache port
  // ========================================
  // committed implies data present
  assign dc_req_valid_o = (count != '0) && sq[head].valid &&
                          sq[head].committed && !sq[head].issued;

  always_comb begin
    dc_req_o.addr    = sq[head].addr;
    dc_req_o.size    = sq[head].size;
    dc_req_o.cmd     = MEM_STORE;
    dc_req_o.data    = sq[head].data;
    dc_req_o.rob_idx = sq[head].rob_idx;
  end

  // ========================================
  // queue state
  // ========================================
  always_ff @(posedge clock) begin
    if (reset) begin
      head                <= '0;
      tail                <= '0;
      count               <= '0;
      store_ready_valid_o <= 1'b0;
      for (int i = 0; i < `SQ_SIZE; i++) begin
        sq[i].valid      <= 1'b0;
        sq[i].addr_valid <= 1'b0;
        sq[i].data_valid <= 1'b0;
        sq[i].committed  <= 1'b0;
        sq[i].issued     <= 1'b0;
      end
    end else begin
      for (int i = 0; i < `SQ_SIZE; i++) begin
        // address and data arrive together, matched by rob index
        if (data_valid_i && sq[i].valid && (sq[i].rob_idx == data_rob_idx_i)) begin
          sq[i].addr       <= data_addr_i;
          sq[i].addr_valid <= 1'b1;
          sq[i].data       <= data_i;
          sq[i].data_valid <= 1'b1;
        end
        if (commit_mask[i]) begin
          sq[i].committed <= 1'b1;
        end
        // younger than the checkpoint
        if (squash_mask[i]) begin
          sq[i].valid      <= 1'b0;
          sq[i].addr_valid <= 1'b0;
          sq[i].data_valid <= 1'b0;
          sq[i].committed  <= 1'b0;
        end
      end

      // one pulse per committed store
      store_ready_valid_o <= |commit_mask;
      if (|commit_mask) begin
        store_ready_idx_o <= rob_head_i;
      end

      // never request the same head twice
      if (do_issue) begin
        sq[head].issued <= 1'b1;
      end
      if (do_free) begin
        sq[head].valid <= 1'b0;
        head           <= head + 1'b1;
      end

      if (restore_valid_i) begin
        tail <= restore_tail_i;
      end else if (do_enq) begin
        // address and data unknown at dispatch
        sq[tail].valid      <= 1'b1;
        sq[tail].addr_valid <= 1'b0;
        sq[tail].size       <= enq_size_i;
        sq[tail].rob_idx    <= enq_rob_idx_i;
        sq[tail].data_valid <= 1'b0;
        sq[tail].committed  <= 1'b0;
        sq[tail].issued     <= 1'b0;
        tail                <= tail + 1'b1;
      end

      count <= count + sq_cnt_t'(do_enq) - sq_cnt_t'(do_free) - squash_n;
    end
  end

  // view for the checkpoint and the forward search
  assign tail_o    = tail;
  assign head_o    = head;
  assign count_o   = count;
  assign entries_o = sq;

endmodule

`default_nettype wire

// ==== source/store_subsystem.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "sq_defs.svh"

module store_subsystem (
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       enq_valid_i,
  input  wire mem_pkg::mem_size_e   enq_size_i,
  input  wire core_pkg::rob_idx_t   enq_rob_idx_i,
  input  wire                       data_valid_i,
  input  wire mem_pkg::addr_t       data_addr_i,
  input  wire mem_pkg::mem_block_u  data_i,
  input  wire core_pkg::rob_idx_t   data_rob_idx_i,
  input  wire core_pkg::rob_idx_t   rob_head_i,
  input  wire                       branch_i,
  input  wire                       restore_i,
  input  wire                       load_valid_i,
  input  wire mem_pkg::addr_t       load_addr_i,
  input  wire mem_pkg::mem_size_e   load_size_i,
  output logic                      full_o,
  output core_pkg::sq_cnt_t         free_slots_o,
  output logic                      store_ready_valid_o,
  output core_pkg::rob_idx_t        store_ready_idx_o,
  output mem_pkg::mem_block_u       load_data_o,
  output logic                      load_stall_o
);
  import core_pkg::*;
  import mem_pkg::*;

  sq_entry_t [`SQ_SIZE-1:0] entries;
  sq_ptr_t                  head;
  sq_ptr_t                  tail;
  sq_ptr_t                  restore_tail;
  sq_cnt_t                  count;
  logic                     restore_valid;
  logic                     dc_req_valid;
  logic                     dc_req_accept;
  logic                     dc_store_valid;
  store_req_t               dc_req;
  fwd_result_t              fwd;
  mem_block_u               load_block;

  // ========================================
  // queue and checkpoint
  // ========================================
  store_queue u_store_queue (
    .clock               (clock),
    .reset               (reset),
    .enq_valid_i         (enq_valid_i),
    .enq_size_i          (enq_size_i),
    .enq_rob_idx_i       (enq_rob_idx_i),
    .data_valid_i        (data_valid_i),
    .data_addr_i         (data_addr_i),
    .data_i              (data_i),
    .data_rob_idx_i      (data_rob_idx_i),
    .rob_head_i          (rob_head_i),
    .restore_valid_i     (restore_valid),
    .restore_tail_i      (restore_tail),
    .dc_req_accept_i     (dc_req_accept),
    .dc_store_valid_i    (dc_store_valid),
    .full_o              (full_o),
    .free_slots_o        (free_slots_o),
    .store_ready_valid_o (store_ready_valid_o),
    .store_ready_idx_o   (store_ready_idx_o),
    .dc_req_valid_o      (dc_req_valid),
    .dc_req_o            (dc_req),
    .tail_o              (tail),
    .entries_o           (entries),
    .head_o              (head),
    .count_o             (count)
  );

  sq_checkpoint u_sq_checkpoint (
    .clock           (clock),
    .reset           (reset),
    .branch_i        (branch_i),
    .restore_i       (restore_i),
    .tail_i          (tail),
    .restore_valid_o (restore_valid),
    .restore_tail_o  (restore_tail)
  );

  // ========================================
  // load path
  // ========================================
  store_forward u_store_forward (
    .load_valid_i (load_valid_i),
    .load_addr_i  (load_addr_i),
    .load_size_i  (load_size_i),
    .entries_i    (entries),
    .head_i       (head),
    .count_i      (count),
    .fwd_o        (fwd)
  );

  // done index not needed, the head is always the one finishing
  dcache_store_port u_dcache_store_port (
    .clock              (clock),
    .reset              (reset),
    .dc_req_valid_i     (dc_req_valid),
    .dc_req_i           (dc_req),
    .load_addr_i        (load_addr_i),
    .load_size_i        (load_size_i),
    .dc_req_accept_o    (dc_req_accept),
    .dc_store_valid_o   (dc_store_valid),
    .dc_store_rob_idx_o (),
    .load_block_o       (load_block)
  );

  // forwarded lanes win over the array
  assign load_data_o  = fwd.hit ? fwd.data : load_block;
  assign load_stall_o = fwd.pending;

endmodule

`default_nettype wire

// ==== tb/store_subsystem_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "sq_defs.svh"

module store_subsystem_tb;
  import mem_pkg::*;
  import core_pkg::*;

  localparam int CLK_HALF     = 10;
  localparam int RESET_CYCLES = 10;
  localparam int INIT_BUDGET  = 150;
  localparam int RAND_CYCLES  = 1100;
  localparam int SWEEP_BUDGET = 50;
  localparam int ROUNDS       = 20;
  localparam int ROUND_BUDGET = 30;
  // twice the expected length of all phases together
  localparam int TIMEOUT_CYCLES =
    2 * (INIT_BUDGET + RAND_CYCLES + 3 * SWEEP_BUDGET + ROUNDS * ROUND_BUDGET);

  // one store as the reference model sees it
  typedef struct packed {
    rob_idx_t    idx;
    addr_t       addr;
    logic [1:0]  size;
    logic [63:0] data;
    logic        has_data;
    logic        committed;
    logic        issued;
    // dispatched after the live checkpoint
    logic        young;
  } model_store_t;

  logic        clock;
  logic        reset;
  logic        enq_valid;
  mem_size_e   enq_size;
  rob_idx_t    enq_rob_idx;
  logic        data_valid;
  addr_t       data_addr;
  mem_block_u  data_blk;
  rob_idx_t    data_rob_idx;
  rob_idx_t    rob_head;
  logic        branch;
  logic        restore;
  logic        load_valid;
  addr_t       load_addr;
  mem_size_e   load_size;
  logic        full;
  sq_cnt_t     free_slots;
  logic        store_ready_valid;
  rob_idx_t    store_ready_idx;
  mem_block_u  load_data;
  logic        load_stall;

  // ========================================
  // model state
  // ========================================
  model_store_t stores[$];
  logic [7:0]   mem_image [128];
  rob_idx_t     next_idx;
  logic         held;
  logic         port_busy;
  logic         port_done;
  logic         exp_ready;
  rob_idx_t     exp_ready_idx;
  logic         enq_taken;
  logic [1:0]   offer_size;
  addr_t        offer_addr;
  int           freed_total;
  int           cycles = 0;
  logic [31:0]  rng_state = 32'd98751;

  store_subsystem u_store_subsystem (
    .clock               (clock),
    .reset               (reset),
    .enq_valid_i         (enq_valid),
    .enq_size_i          (enq_size),
    .enq_rob_idx_i       (enq_rob_idx),
    .data_valid_i        (data_valid),
    .data_addr_i         (data_addr),
    .data_i              (data_blk),
    .data_rob_idx_i      (data_rob_idx),
    .rob_head_i          (rob_head),
    .branch_i            (branch),
    .restore_i           (restore),
    .load_valid_i        (load_valid),
    .load_addr_i         (load_addr),
    .load_size_i         (load_size),
    .full_o              (full),
    .free_slots_o        (free_slots),
    .store_ready_valid_o (store_ready_valid),
    .store_ready_idx_o   (store_ready_idx),
    .load_data_o         (load_data),
    .load_stall_o        (load_stall)
  );

  initial begin
    clock = 1'b0;
    forever #CLK_HALF clock = ~clock;
  end

  // xorshift32 with state kept across calls
  function logic [31:0] rand32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // 2**size lanes starting at offset a mod 8
  function automatic logic [7:0] lanes_of(addr_t a, logic [1:0] size);
    logic [7:0] m;
    int first;
    int n;
    first = int'(a[2:0]);
    n     = 1 << size;
    for (int b = 0; b < 8; b++) begin
      m[b] = (b >= first) && (b < first + n);
    end
    return m;
  endfunction

  // naturally aligned address inside the 128 byte array
  function automatic addr_t aligned_addr(logic [31:0] r, logic [1:0] size);
    addr_t a;
    a      = {25'd0, r[6:0]};
    a[2:0] = a[2:0] & ~3'((4'd1 << size) - 4'd1);
    return a;
  endfunction

  task automatic fail_and_stop(string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      fail_and_stop($sformatf("Mismatch at %0t: %s got %0h expected %0h",
                              $time, name, got, exp));
    end
  endtask

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      fail_and_stop($sformatf("timeout after %0d cycles, the run did not finish", cycles));
    end
  end

  // ========================================
  // reference predictions
  // ========================================
  // youngest overlapping store decides
  // a store without data counts as overlap
  task automatic predict_load(output logic stall, output logic [63:0] data);
    logic [7:0] lm;
    logic [7:0] sm;
    logic       found;
    lm    = lanes_of(load_addr, load_size);
    found = 1'b0;
    stall = 1'b0;
    data  = '0;
    for (int i = stores.size() - 1; i >= 0; i--) begin
      sm = lanes_of(stores[i].addr, stores[i].size);
      if (!found && !stores[i].has_data) begin
        found = 1'b1;
        stall = 1'b1;
      end else if (!found && (stores[i].addr[31:3] == load_addr[31:3]) && |(sm & lm)) begin
        found = 1'b1;
        // partial cover stalls the load
        stall = ((sm & lm) != lm);
        for (int b = 0; b < 8; b++) begin
          if (lm[b]) data[8*b +: 8] = stores[i].data[8*b +: 8];
        end
      end
    end
    if (!found) begin
      for (int b = 0; b < 8; b++) begin
        if (lm[b]) data[8*b +: 8] = mem_image[int'(load_addr[6:3]) * 8 + b];
      end
    end
  endtask

  task automatic check_outputs();
    logic        stall;
    logic [63:0] data;
    check_value("free_slots_o", 64'(free_slots), 64'(`SQ_SIZE - stores.size()));
    check_value("full_o", 64'(full), 64'(stores.size() == `SQ_SIZE));
    check_value("store_ready_valid_o", 64'(store_ready_valid), 64'(exp_ready));
    if (exp_ready) begin
      check_value("store_ready_idx_o", 64'(store_ready_idx), 64'(exp_ready_idx));
    end
    if (load_valid) begin
      predict_load(stall, data);
      check_value("load_stall_o", 64'(load_stall), 64'(stall));
      if (!stall) check_value("load_data_o", load_data, data);
    end
  endtask

  // what the coming edge does to queue, port and memory
  task automatic update_model();
    model_store_t s;
    logic         take;
    logic         can_enq;
    logic [7:0]   lm;
    can_enq   = (stores.size() < `SQ_SIZE);
    take      = (stores.size() != 0) && stores[0].committed && !stores[0].issued && !port_busy;
    exp_ready = 1'b0;
    enq_taken = 1'b0;
    // commit needs data captured at an earlier edge
    for (int i = 0; i < stores.size(); i++) begin
      s = stores[i];
      if (s.idx == rob_head && s.has_data && !s.committed) begin
        s.committed   = 1'b1;
        stores[i]     = s;
        exp_ready     = 1'b1;
        exp_ready_idx = rob_head;
      end
    end
    for (int i = 0; i < stores.size(); i++) begin
      s = stores[i];
      if (data_valid && s.idx == data_rob_idx) begin
        s.has_data = 1'b1;
        stores[i]  = s;
      end
    end
    if (take) begin
      s         = stores[0];
      s.issued  = 1'b1;
      stores[0] = s;
      lm        = lanes_of(s.addr, s.size);
      for (int b = 0; b < 8; b++) begin
        if (lm[b]) mem_image[int'(s.addr[6:3]) * 8 + b] = s.data[8*b +: 8];
      end
    end
    // done pulse frees the head
    if (port_done) begin
      void'(stores.pop_front());
      freed_total++;
    end
    if (restore && held) begin
      while (stores.size() != 0 && stores[stores.size() - 1].young) begin
        void'(stores.pop_back());
      end
      held = 1'b0;
    end else if (enq_valid && can_enq) begin
      s.idx       = enq_rob_idx;
      s.addr      = offer_addr;
      s.size      = offer_size;
      s.data      = {rand32(), rand32()};
      s.has_data  = 1'b0;
      s.committed = 1'b0;
      s.issued    = 1'b0;
      s.young     = held;
      stores.push_back(s);
      next_idx    = next_idx + 1'b1;
      enq_taken   = 1'b1;
    end
    if (branch) held = 1'b1;
    port_done = port_busy;
    port_done = port_done;
    port_busy = take;
  endtask

  // ========================================
  // stimulus
  // ========================================
  // oldest uncommitted store older than the live checkpoint
  // the next dispatch index when there is none
  task automatic drive_rob_head();
    rob_head = next_idx;
    for (int i = stores.size() - 1; i >= 0; i--) begin
      if (!stores[i].committed && !stores[i].young) rob_head = stores[i].idx;
    end
  endtask

  task automatic step();
    @(negedge clock);
    check_outputs();
    update_model();
    @(posedge clock);
    #2;
    enq_valid  = 1'b0;
    data_valid = 1'b0;
    branch     = 1'b0;
    restore    = 1'b0;
    load_valid = 1'b0;
    drive_rob_head();
  endtask

  task automatic pick_offer();
    logic [31:0] r;
    r          = rand32();
    offer_size = r[1:0];
    offer_addr = aligned_addr(rand32(), r[1:0]);
  endtask

  task automatic drive_enq();
    enq_valid   = 1'b1;
    enq_size    = mem_size_e'(offer_size);
    enq_rob_idx = next_idx;
  endtask

  // any store still waiting for its data
  task automatic send_some_data();
    int           pick[$];
    model_store_t s;
    for (int i = 0; i < stores.size(); i++) begin
      if (!stores[i].has_data) pick.push_back(i);
    end
    if (pick.size() != 0) begin
      s                   = stores[pick[rand32() % pick.size()]];
      data_valid          = 1'b1;
      data_addr           = s.addr;
      data_blk.dbbl_level = s.data;
      data_rob_idx        = s.idx;
    end
  endtask

  task automatic drive_load();
    logic [31:0] r;
    r          = rand32();
    load_size  = mem_size_e'(r[1:0]);
    load_addr  = aligned_addr(rand32(), r[1:0]);
    load_valid = 1'b1;
  endtask

  // offered again each cycle until the queue takes it
  task automatic enqueue_one(logic with_loads);
    pick_offer();
    do begin
      drive_enq();
      send_some_data();
      if (with_loads && rand32() % 2 == 0) drive_load();
      step();
    end while (!enq_taken);
  endtask

  task automatic drain_queue();
    while (stores.size() != 0) begin
      send_some_data();
      step();
    end
  endtask

  // one random load per doubleword against an empty queue
  task automatic sweep_memory();
    logic [31:0] r;
    drain_queue();
    for (int line = 0; line < `DC_LINES; line++) begin
      r              = rand32();
      load_size      = mem_size_e'(r[1:0]);
      load_addr      = aligned_addr(rand32(), r[1:0]);
      load_addr[6:3] = 4'(line);
      load_valid     = 1'b1;
      step();
    end
  endtask

  initial begin
    int  n_pre;
    int  n_post;
    int  free_at_branch;
    int  freed_base;
    logic want_enq;
    logic heavy;
    reset        = 1'b1;
    enq_valid    = 1'b0;
    enq_size     = MEM_BYTE;
    enq_rob_idx  = '0;
    data_valid   = 1'b0;
    data_addr    = '0;
    data_blk     = '0;
    data_rob_idx = '0;
    rob_head     = '0;
    branch       = 1'b0;
    restore      = 1'b0;
    load_valid   = 1'b0;
    load_addr    = '0;
    load_size    = MEM_BYTE;
    next_idx     = '0;
    held         = 1'b0;
    port_busy    = 1'b0;
    port_done    = 1'b0;
    exp_ready    = 1'b0;
    enq_taken    = 1'b0;
    freed_total  = 0;
    want_enq     = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    #2;
    reset = 1'b0;
    check_value("full_o", 64'(full), 64'd0);
    check_value("store_ready_valid_o", 64'(store_ready_valid), 64'd0);
    check_value("free_slots_o", 64'(free_slots), 64'(`SQ_SIZE));

    // fill every doubleword so later loads see known data
    for (int line = 0; line < `DC_LINES; line++) begin
      offer_size = 2'd3;
      offer_addr = addr_t'(line * 8);
      do begin
        drive_enq();
        send_some_data();
        step();
      end while (!enq_taken);
    end
    sweep_memory();

    // ========================================
    // random traffic in busy and quiet spells
    // ========================================
    for (int c = 0; c < RAND_CYCLES; c++) begin
      heavy = ((c / 100) % 2) == 0;
      if (!want_enq && (rand32() % 100) < (heavy ? 70 : 15)) begin
        pick_offer();
        want_enq = 1'b1;
      end
      if (want_enq) drive_enq();
      if (rand32() % 100 < 50) send_some_data();
      if (rand32() % 100 < 40) drive_load();
      step();
      if (enq_taken) want_enq = 1'b0;
    end
    sweep_memory();

    // ========================================
    // branch then wrong-path stores then restore
    // ========================================
    for (int r = 0; r < ROUNDS; r++) begin
      n_pre = rand32() % 3;
      for (int j = 0; j < n_pre; j++) enqueue_one(1'b1);
      branch         = 1'b1;
      free_at_branch = `SQ_SIZE - stores.size();
      freed_base     = freed_total;
      send_some_data();
      step();
      n_post = 1 + rand32() % 3;
      for (int j = 0; j < n_post; j++) enqueue_one(1'b1);
      repeat (2) begin
        drive_load();
        send_some_data();
        step();
      end
      // an enqueue in the restore cycle must lose
      restore = 1'b1;
      if (rand32() % 2 == 0) begin
        pick_offer();
        drive_enq();
      end
      step();
      check_value("free_slots_o after restore", 64'(free_slots),
                  64'(free_at_branch + (freed_total - freed_base)));
    end
    sweep_memory();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+source
source/mem_pkg.sv
source/core_pkg.sv
source/store_queue.sv
source/sq_checkpoint.sv
source/store_forward.sv
source/dcache_store_port.sv
source/store_subsystem.sv
tb/store_subsystem_tb.sv
